// ==== tb.f ====
hdl/mul_op_pkg.sv
hdl/mul_data_pkg.sv
hdl/bitmanip_perm.sv
hdl/crc_reduce.sv
hdl/bitmanip_unit.sv
hdl/mul_datapath.sv
hdl/mul_ctrl.sv
hdl/mul_unit.sv
dv/tb_clk_gen.sv
dv/mul_unit_sva.sv
dv/mul_unit_tb.sv

// ==== Bender.yml ====
package:
  name: mul_unit

sources:
  - hdl/mul_op_pkg.sv
  - hdl/mul_data_pkg.sv
  - hdl/bitmanip_perm.sv
  - hdl/crc_reduce.sv
  - hdl/bitmanip_unit.sv
  - hdl/mul_datapath.sv
  - hdl/mul_ctrl.sv
  - hdl/mul_unit.sv
  - target: simulation
    files:
      - dv/tb_clk_gen.sv
      - dv/mul_unit_sva.sv
      - dv/mul_unit_tb.sv

// ==== dv/mul_unit_tb.sv ====
// Self-checking testbench for mul_unit; expects one result per valid_i, one cycle later
`timescale 1ns/1ps

module mul_unit_tb;

   localparam int          CLK_PERIOD_NS = 20;
   localparam int          RESET_CYCLES  = 16;
   localparam int unsigned SEED          = 32'h353fae4a;
   localparam int          N_RAND        = 24;
   localparam int          N_CRC         = 8;
   localparam int          N_OPS = 4 * (N_RAND + 2) + 12 + 65 + 48 + 6 * (N_CRC + 1) + 6;
   // At most three cycles per op, plus reset and drain
   localparam int          TIMEOUT_CYCLES = N_OPS * 3 + RESET_CYCLES + 20;

   // Standard (non-reflected) generator polynomials
   localparam mul_data_pkg::word_t CRC32_POLY  = 32'h04C1_1DB7;
   localparam mul_data_pkg::word_t CRC32C_POLY = 32'h1EDC_6F41;

   logic                clk;
   logic                rst_n;
   logic                valid;
   mul_op_pkg::op_t     op;
   mul_data_pkg::word_t rs1;
   mul_data_pkg::word_t rs2;
   logic                result_valid;
   mul_data_pkg::word_t result;

   mul_data_pkg::word_t exp_q [$];
   int                  cyc_q [$];
   mul_data_pkg::word_t last_result = '0;
   int                  cycle = 0;
   int                  value_errors = 0;
   int                  proto_errors = 0;

   tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) i_tb_clk_gen
   (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   mul_unit i_mul_unit
   (
      .clk            (clk),
      .rst_n_i        (rst_n),
      .valid_i        (valid),
      .op_i           (op),
      .rs1_i          (rs1),
      .rs2_i          (rs2),
      .result_valid_o (result_valid),
      .result_o       (result)
   );

   bind mul_unit mul_unit_sva i_mul_unit_sva
   (
      .clk_i          (clk),
      .rst_n_i        (rst_n_i),
      .valid_i        (valid_i),
      .result_valid_i (result_valid_o),
      .result_i       (result_o)
   );

   // Output bit p takes input bit p xor k
   function automatic mul_data_pkg::word_t grev_ref(mul_data_pkg::word_t x, logic [4:0] k);
      mul_data_pkg::word_t r;
      for (int p = 0; p < 32; p++)
         r[p] = x[p ^ k];
      return r;
   endfunction

   // OR over every index reachable with a subset of the control bits
   function automatic mul_data_pkg::word_t gorc_ref(mul_data_pkg::word_t x, logic [4:0] k);
      mul_data_pkg::word_t r;
      r = '0;
      for (int p = 0; p < 32; p++)
      begin
         for (int m = 0; m < 32; m++)
         begin
            if ((m & ~k) == 0)
               r[p] = r[p] | x[p ^ m];
         end
      end
      return r;
   endfunction

   // Shuffle stage i exchanges index bits i and i+1
   function automatic mul_data_pkg::word_t index_swap(mul_data_pkg::word_t x, int i);
      mul_data_pkg::word_t r;
      int                  q;
      for (int p = 0; p < 32; p++)
      begin
         q = (p & ~(3 << i)) | (((p >> i) & 1) << (i + 1)) | (((p >> (i + 1)) & 1) << i);
         r[p] = x[q];
      end
      return r;
   endfunction

   function automatic mul_data_pkg::word_t shuffle_ref(mul_data_pkg::word_t x,
                                                       logic [3:0] k, logic inverse);
      mul_data_pkg::word_t r;
      int                  s;
      r = x;
      for (int n = 0; n < 4; n++)
      begin
         s = inverse ? n : 3 - n;
         if (k[s])
            r = index_swap(r, s);
      end
      return r;
   endfunction

   // Reflected CRC, polynomial reversed here from its standard form
   function automatic mul_data_pkg::word_t crc_ref(mul_data_pkg::word_t x,
                                                   mul_data_pkg::word_t poly_std, int nbits);
      mul_data_pkg::word_t poly;
      mul_data_pkg::word_t c;
      for (int i = 0; i < 32; i++)
         poly[i] = poly_std[31 - i];
      c = x;
      repeat (nbits)
      begin
         if (c[0])
            c = (c >> 1) ^ poly;
         else
            c = c >> 1;
      end
      return c;
   endfunction

   function automatic mul_data_pkg::word_t ref_result(mul_op_pkg::op_t op_v,
                                                      mul_data_pkg::word_t a,
                                                      mul_data_pkg::word_t b);
      logic [63:0] a_ext;
      logic [63:0] b_ext;
      logic [63:0] prod;
      a_ext = {{32{a[31] && op_v != mul_op_pkg::OP_MULHU}}, a};
      b_ext = {{32{b[31] && op_v == mul_op_pkg::OP_MULH}}, b};
      prod  = a_ext * b_ext;
      case (op_v)
         mul_op_pkg::OP_MULH,
         mul_op_pkg::OP_MULHSU,
         mul_op_pkg::OP_MULHU:    return prod[63:32];
         mul_op_pkg::OP_GREV:     return grev_ref(a, b[4:0]);
         mul_op_pkg::OP_GORC:     return gorc_ref(a, b[4:0]);
         mul_op_pkg::OP_SHFL:     return shuffle_ref(a, b[3:0], 1'b0);
         mul_op_pkg::OP_UNSHFL:   return shuffle_ref(a, b[3:0], 1'b1);
         mul_op_pkg::OP_CRC32_B:  return crc_ref(a, CRC32_POLY, 8);
         mul_op_pkg::OP_CRC32_H:  return crc_ref(a, CRC32_POLY, 16);
         mul_op_pkg::OP_CRC32_W:  return crc_ref(a, CRC32_POLY, 32);
         mul_op_pkg::OP_CRC32C_B: return crc_ref(a, CRC32C_POLY, 8);
         mul_op_pkg::OP_CRC32C_H: return crc_ref(a, CRC32C_POLY, 16);
         mul_op_pkg::OP_CRC32C_W: return crc_ref(a, CRC32C_POLY, 32);
         // Spare bit-manip codes give zero, spare multiply codes the low word
         default:                 return op_v[4] ? '0 : prod[31:0];
      endcase
   endfunction

   task automatic check_word(string name, mul_data_pkg::word_t expected,
                             mul_data_pkg::word_t actual);
      if (actual !== expected)
      begin
         value_errors++;
         $display("FAILED %s expected %h actual %h at %0t", name, expected, actual, $time);
      end
   endtask

   // One op, then zero to two idle cycles with junk on the data inputs
   task automatic drive_op(mul_op_pkg::op_t op_v, mul_data_pkg::word_t a,
                           mul_data_pkg::word_t b, mul_data_pkg::word_t expected);
      int gap;
      @(posedge clk);
      #2;
      valid = 1'b1;
      op    = op_v;
      rs1   = a;
      rs2   = b;
      exp_q.push_back(expected);
      cyc_q.push_back(cycle);
      gap = $urandom % 3;
      repeat (gap)
      begin
         @(posedge clk);
         #2;
         valid = 1'b0;
         op    = mul_op_pkg::op_t'($urandom);
         rs1   = $urandom;
         rs2   = $urandom;
      end
   endtask

   task automatic run_op(mul_op_pkg::op_t op_v, mul_data_pkg::word_t a,
                         mul_data_pkg::word_t b);
      drive_op(op_v, a, b, ref_result(op_v, a, b));
   endtask

   always @(posedge clk)
      cycle <= cycle + 1;

   always @(negedge clk)
   begin
      if (!rst_n)
      begin
         if (result_valid !== 1'b0)
         begin
            proto_errors++;
            $display("result_valid_o is not low during reset at %0t", $time);
         end
      end
      else if (result_valid === 1'b1)
      begin
         if (exp_q.size() == 0)
         begin
            proto_errors++;
            $display("A result appeared with no operation pending at %0t", $time);
         end
         else
         begin
            if (cyc_q[0] + 1 != cycle)
            begin
               proto_errors++;
               $display("Op of cycle %0d returned in cycle %0d", cyc_q[0], cycle);
            end
            last_result = exp_q.pop_front();
            void'(cyc_q.pop_front());
            check_word("result_o", last_result, result);
         end
      end
      else
      begin
         if (exp_q.size() != 0 && cyc_q[0] < cycle)
         begin
            proto_errors++;
            $display("No result one cycle after the op of cycle %0d", cyc_q[0]);
            void'(exp_q.pop_front());
            void'(cyc_q.pop_front());
         end
         // Idle cycle, result must hold
         check_word("result_o", last_result, result);
      end
   end

   initial
   begin
      #(TIMEOUT_CYCLES * CLK_PERIOD_NS);
      $display("Timeout after %0d cycles, the operations did not complete", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $finish;
   end

   initial
   begin
      mul_op_pkg::op_t     mul_ops [4];
      mul_op_pkg::op_t     crc_ops [6];
      mul_data_pkg::word_t a;
      mul_data_pkg::word_t b;
      mul_data_pkg::word_t k;
      mul_data_pkg::word_t x;
      int                  sva_errors;
      mul_ops = '{mul_op_pkg::OP_MUL, mul_op_pkg::OP_MULH,
                  mul_op_pkg::OP_MULHSU, mul_op_pkg::OP_MULHU};
      crc_ops = '{mul_op_pkg::OP_CRC32_B, mul_op_pkg::OP_CRC32_H, mul_op_pkg::OP_CRC32_W,
                  mul_op_pkg::OP_CRC32C_B, mul_op_pkg::OP_CRC32C_H, mul_op_pkg::OP_CRC32C_W};
      void'($urandom(SEED));
      valid = 1'b0;
      op    = '0;
      rs1   = '0;
      rs2   = '0;
      wait (rst_n === 1'b1);
      repeat (4) @(posedge clk);

      // Multiply with bit 31 forced on part of the operands
      for (int v = 0; v < 4; v++)
      begin
         for (int j = 0; j < N_RAND; j++)
         begin
            a     = $urandom;
            b     = $urandom;
            a[31] = a[31] | j[0];
            b[31] = b[31] | j[1];
            run_op(mul_ops[v], a, b);
         end
         run_op(mul_ops[v], 32'hFFFF_FFFF, 32'h8000_0000);
         run_op(mul_ops[v], 32'h8000_0000, 32'h8000_0000);
      end
      for (int c = 4; c < 16; c++)
         run_op(mul_op_pkg::op_t'(c), $urandom, $urandom);

      for (int c = 0; c < 32; c++)
      begin
         k      = $urandom;
         k[4:0] = c[4:0];
         run_op(mul_op_pkg::OP_GREV, $urandom, k);
         run_op(mul_op_pkg::OP_GORC, $urandom, k);
      end
      // Full bit reversal
      drive_op(mul_op_pkg::OP_GREV, 32'h1234_5678, 32'd31, 32'h1E6A_2C48);

      for (int c = 0; c < 16; c++)
      begin
         k      = $urandom;
         k[3:0] = c[3:0];
         x      = $urandom;
         run_op(mul_op_pkg::OP_SHFL, x, k);
         run_op(mul_op_pkg::OP_UNSHFL, $urandom, k);
         drive_op(mul_op_pkg::OP_UNSHFL, shuffle_ref(x, k[3:0], 1'b0), k, x);
      end

      for (int j = 0; j <= N_CRC; j++)
      begin
         a = (j == N_CRC) ? 32'hFFFF_FFFF : $urandom;
         for (int c = 0; c < 6; c++)
            run_op(crc_ops[c], a, $urandom);
      end

      // Six spare bit-manip codes
      for (int c = 10; c < 16; c++)
         run_op(mul_op_pkg::op_t'(16 + c), $urandom, $urandom);

      @(posedge clk);
      #2;
      valid = 1'b0;
      while (exp_q.size() != 0)
         @(posedge clk);
      repeat (3) @(posedge clk);

      sva_errors = i_mul_unit.i_mul_unit_sva.fail_count;
      $display("Errors: %0d value, %0d protocol, %0d assertion",
               value_errors, proto_errors, sva_errors);
      if (value_errors + proto_errors + sva_errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// ==== dv/mul_unit_sva.sv ====
// Port-level checks for mul_unit; all but the reset check are off while rst_n_i is low
`timescale 1ns/1ps

module mul_unit_sva
(
   input logic                clk_i,
   input logic                rst_n_i,
   input logic                valid_i,
   input logic                result_valid_i,
   input mul_data_pkg::word_t result_i
);

   int fail_count = 0;

   // One result per accepted op, one cycle later
   valid_follows: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                   result_valid_i == $past(valid_i))
   else
   begin
      fail_count++;
      $error("result_valid_o does not follow valid_i by one cycle");
   end

   reset_quiet: assert property (@(posedge clk_i) !rst_n_i |-> !result_valid_i)
   else
   begin
      fail_count++;
      $error("result_valid_o high during reset");
   end

   // No op taken, so the result register holds
   idle_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                               !valid_i |=> $stable(result_i))
   else
   begin
      fail_count++;
      $error("result_o changed after a cycle without valid_i");
   end

endmodule

// ==== dv/tb_clk_gen.sv ====
// Clock runs from time zero; reset is released 2 ns after the last rising edge of the reset phase
`timescale 1ns/1ps

module tb_clk_gen
#(
   parameter int PERIOD_NS    = 20,
   parameter int RESET_CYCLES = 16
)
(
   output logic clk_o,
   output logic rst_n_o
);

   initial
   begin
      clk_o   = 1'b0;
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #2;
      rst_n_o = 1'b1;
   end

   always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

// ==== hdl/mul_unit.sv ====
// Result one cycle after valid_i with no back-pressure; consumer must sample on result_valid_o
`timescale 1ns/1ps

module mul_unit
(
   input  logic                clk,
   input  logic                rst_n_i,
   input  logic                valid_i,
   input  mul_op_pkg::op_t     op_i,
   input  mul_data_pkg::word_t rs1_i,
   input  mul_data_pkg::word_t rs2_i,
   output logic                result_valid_o,
   output mul_data_pkg::word_t result_o
);

   logic                rs1_signed;
   logic                rs2_signed;
   mul_data_pkg::prod_t prod;
   mul_data_pkg::word_t bm_result;

   mul_ctrl i_mul_ctrl
   (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .valid_i        (valid_i),
      .op_i           (op_i),
      .prod_i         (prod),
      .bm_result_i    (bm_result),
      .rs1_signed_o   (rs1_signed),
      .rs2_signed_o   (rs2_signed),
      .result_valid_o (result_valid_o),
      .result_o       (result_o)
   );

   mul_datapath i_mul_datapath
   (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .valid_i      (valid_i),
      .rs1_i        (rs1_i),
      .rs2_i        (rs2_i),
      .rs1_signed_i (rs1_signed),
      .rs2_signed_i (rs2_signed),
      .prod_o       (prod)
   );

   bitmanip_unit i_bitmanip_unit
   (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .valid_i     (valid_i),
      .func_i      (mul_op_pkg::op_func(op_i)),
      .rs1_i       (rs1_i),
      .rs2_i       (rs2_i),
      .bm_result_o (bm_result)
   );

endmodule

// ==== hdl/mul_ctrl.sv ====
// No back-pressure; class and low flag load only on valid_i, so result_o holds while idle
`timescale 1ns/1ps

module mul_ctrl
(
   input  logic                clk,
   input  logic                rst_n_i,
   input  logic                valid_i,
   input  mul_op_pkg::op_t     op_i,
   input  mul_data_pkg::prod_t prod_i,
   input  mul_data_pkg::word_t bm_result_i,
   output logic                rs1_signed_o,
   output logic                rs2_signed_o,
   output logic                result_valid_o,
   output mul_data_pkg::word_t result_o
);

   logic low_d;
   logic valid_q;
   logic bm_sel_q;
   logic low_q;

   // Sign and word select per multiply variant
   always_comb
   begin
      rs1_signed_o = 1'b1;
      rs2_signed_o = 1'b1;
      low_d        = 1'b1;
      case (op_i)
         mul_op_pkg::OP_MULH:
         begin
            low_d = 1'b0;
         end
         mul_op_pkg::OP_MULHSU:
         begin
            rs2_signed_o = 1'b0;
            low_d        = 1'b0;
         end
         mul_op_pkg::OP_MULHU:
         begin
            rs1_signed_o = 1'b0;
            rs2_signed_o = 1'b0;
            low_d        = 1'b0;
         end
         default:
         begin
            low_d = 1'b1;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         valid_q  <= 1'b0;
         bm_sel_q <= 1'b0;
         low_q    <= 1'b0;
      end
      else
      begin
         valid_q <= valid_i;
         if (valid_i)
         begin
            bm_sel_q <= mul_op_pkg::op_is_bitmanip(op_i);
            low_q    <= low_d;
         end
      end
   end

   assign result_valid_o = valid_q;

   // Bit-manip result, else low or high product word
   assign result_o = bm_sel_q ? bm_result_i :
                     low_q    ? prod_i[31:0] :
                                prod_i[63:32];

endmodule

// ==== hdl/mul_datapath.sv ====
// One-cycle 33x33 signed multiply; operands register only on valid_i, product is combinational
`timescale 1ns/1ps

module mul_datapath
(
   input  logic                clk,
   input  logic                rst_n_i,
   input  logic                valid_i,
   input  mul_data_pkg::word_t rs1_i,
   input  mul_data_pkg::word_t rs2_i,
   input  logic                rs1_signed_i,
   input  logic                rs2_signed_i,
   output mul_data_pkg::prod_t prod_o
);

   mul_data_pkg::word_ext_t rs1_ext;
   mul_data_pkg::word_ext_t rs2_ext;
   mul_data_pkg::word_ext_t rs1_q;
   mul_data_pkg::word_ext_t rs2_q;

   // Unsigned operand gets a zero extension bit
   assign rs1_ext = {rs1_signed_i & rs1_i[31], rs1_i};
   assign rs2_ext = {rs2_signed_i & rs2_i[31], rs2_i};

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         rs1_q <= '0;
         rs2_q <= '0;
      end
      else if (valid_i)
      begin
         rs1_q <= rs1_ext;
         rs2_q <= rs2_ext;
      end
   end

   // Both operands signed, so one multiplier covers all variants
   assign prod_o = $signed(rs1_q) * $signed(rs2_q);

endmodule

// ==== hdl/bitmanip_unit.sv ====
// Result registers only on valid_i, whatever the op class; unknown function codes give zero
`timescale 1ns/1ps

module bitmanip_unit
(
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  logic                  valid_i,
   input  mul_op_pkg::bm_func_t  func_i,
   input  mul_data_pkg::word_t   rs1_i,
   input  mul_data_pkg::word_t   rs2_i,
   output mul_data_pkg::word_t   bm_result_o
);

   mul_data_pkg::word_t grev;
   mul_data_pkg::word_t gorc;
   mul_data_pkg::word_t shfl;
   mul_data_pkg::word_t unshfl;
   mul_data_pkg::word_t crc32_b;
   mul_data_pkg::word_t crc32_h;
   mul_data_pkg::word_t crc32_w;
   mul_data_pkg::word_t crc32c_b;
   mul_data_pkg::word_t crc32c_h;
   mul_data_pkg::word_t crc32c_w;
   mul_data_pkg::word_t bm_d;

   bitmanip_perm i_bitmanip_perm
   (
      .rs1_i    (rs1_i),
      .rs2_i    (rs2_i),
      .grev_o   (grev),
      .gorc_o   (gorc),
      .shfl_o   (shfl),
      .unshfl_o (unshfl)
   );

   // CRC works on rs1 alone
   crc_reduce i_crc_reduce
   (
      .data_i     (rs1_i),
      .crc32_b_o  (crc32_b),
      .crc32_h_o  (crc32_h),
      .crc32_w_o  (crc32_w),
      .crc32c_b_o (crc32c_b),
      .crc32c_h_o (crc32c_h),
      .crc32c_w_o (crc32c_w)
   );

   always_comb
   begin
      case (func_i)
         mul_op_pkg::FN_GREV:     bm_d = grev;
         mul_op_pkg::FN_GORC:     bm_d = gorc;
         mul_op_pkg::FN_SHFL:     bm_d = shfl;
         mul_op_pkg::FN_UNSHFL:   bm_d = unshfl;
         mul_op_pkg::FN_CRC32_B:  bm_d = crc32_b;
         mul_op_pkg::FN_CRC32_H:  bm_d = crc32_h;
         mul_op_pkg::FN_CRC32_W:  bm_d = crc32_w;
         mul_op_pkg::FN_CRC32C_B: bm_d = crc32c_b;
         mul_op_pkg::FN_CRC32C_H: bm_d = crc32c_h;
         mul_op_pkg::FN_CRC32C_W: bm_d = crc32c_w;
         default:                 bm_d = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         bm_result_o <= '0;
      else if (valid_i)
         bm_result_o <= bm_d;
   end

endmodule

// ==== hdl/crc_reduce.sv ====
// Reflected CRC fold of data_i only; caller pre-XORs the running CRC with the input data
`timescale 1ns/1ps

module crc_reduce
(
   input  mul_data_pkg::word_t data_i,
   output mul_data_pkg::word_t crc32_b_o,
   output mul_data_pkg::word_t crc32_h_o,
   output mul_data_pkg::word_t crc32_w_o,
   output mul_data_pkg::word_t crc32c_b_o,
   output mul_data_pkg::word_t crc32c_h_o,
   output mul_data_pkg::word_t crc32c_w_o
);

   // Shift right, fold in poly when the dropped bit is set
   function automatic mul_data_pkg::word_t crc_fold(mul_data_pkg::word_t data,
                                                    mul_data_pkg::word_t poly,
                                                    int steps);
      mul_data_pkg::word_t crc;
      crc = data;
      for (int i = 0; i < 32; i++)
      begin
         if (i < steps)
            crc = (crc >> 1) ^ (poly & {32{crc[0]}});
      end
      return crc;
   endfunction

   assign crc32_b_o  = crc_fold(data_i, mul_data_pkg::CRC32_POLY_REV, 8);
   assign crc32_h_o  = crc_fold(data_i, mul_data_pkg::CRC32_POLY_REV, 16);
   assign crc32_w_o  = crc_fold(data_i, mul_data_pkg::CRC32_POLY_REV, 32);
   assign crc32c_b_o = crc_fold(data_i, mul_data_pkg::CRC32C_POLY_REV, 8);
   assign crc32c_h_o = crc_fold(data_i, mul_data_pkg::CRC32C_POLY_REV, 16);
   assign crc32c_w_o = crc_fold(data_i, mul_data_pkg::CRC32C_POLY_REV, 32);

endmodule

// ==== hdl/bitmanip_perm.sv ====
// Permutation networks for 32-bit words only; grev/gorc use rs2[4:0], shfl/unshfl rs2[3:0]
`timescale 1ns/1ps

module bitmanip_perm
(
   input  mul_data_pkg::word_t rs1_i,
   input  mul_data_pkg::word_t rs2_i,
   output mul_data_pkg::word_t grev_o,
   output mul_data_pkg::word_t gorc_o,
   output mul_data_pkg::word_t shfl_o,
   output mul_data_pkg::word_t unshfl_o
);

   // Low half of each swapped pair, stage i swaps by 2**i
   localparam mul_data_pkg::word_t SWAP_MASK [5] = '{
      32'h5555_5555, 32'h3333_3333, 32'h0F0F_0F0F, 32'h00FF_00FF, 32'h0000_FFFF
   };

   // Shuffle stage i moves the inner fields of each 4*2**i block
   localparam mul_data_pkg::word_t SHFL_L [4] = '{
      32'h4444_4444, 32'h3030_3030, 32'h0F00_0F00, 32'h00FF_0000
   };
   localparam mul_data_pkg::word_t SHFL_R [4] = '{
      32'h2222_2222, 32'h0C0C_0C0C, 32'h00F0_00F0, 32'h0000_FF00
   };

   mul_data_pkg::word_t grev_x;
   mul_data_pkg::word_t gorc_x;
   mul_data_pkg::word_t shfl_x;
   mul_data_pkg::word_t unshfl_x;

   function automatic mul_data_pkg::word_t swap_stage(mul_data_pkg::word_t x, int i);
      return ((x & SWAP_MASK[i]) << (1 << i)) | ((x >> (1 << i)) & SWAP_MASK[i]);
   endfunction

   function automatic mul_data_pkg::word_t shfl_stage(mul_data_pkg::word_t x, int i);
      return (x & ~(SHFL_L[i] | SHFL_R[i])) |
             ((x << (1 << i)) & SHFL_L[i]) |
             ((x >> (1 << i)) & SHFL_R[i]);
   endfunction

   always_comb
   begin
      grev_x = rs1_i;
      gorc_x = rs1_i;
      for (int i = 0; i < 5; i++)
      begin
         if (rs2_i[i])
         begin
            grev_x = swap_stage(grev_x, i);
            gorc_x = gorc_x | swap_stage(gorc_x, i);
         end
      end
   end

   // Shuffle runs coarse to fine, unshuffle fine to coarse
   always_comb
   begin
      shfl_x   = rs1_i;
      unshfl_x = rs1_i;
      for (int i = 3; i >= 0; i--)
      begin
         if (rs2_i[i])
            shfl_x = shfl_stage(shfl_x, i);
      end
      for (int i = 0; i < 4; i++)
      begin
         if (rs2_i[i])
            unshfl_x = shfl_stage(unshfl_x, i);
      end
   end

   assign grev_o   = grev_x;
   assign gorc_o   = gorc_x;
   assign shfl_o   = shfl_x;
   assign unshfl_o = unshfl_x;

endmodule

// ==== hdl/mul_data_pkg.sv ====
// Datapath is fixed at 32 bits; CRC polynomials are given in reflected (LSB first) form
package mul_data_pkg;

   typedef logic [31:0] word_t;

   // Operand plus one extension bit for the mixed-sign multiply
   typedef logic [32:0] word_ext_t;

   // Full signed product of two extended operands
   typedef logic [65:0] prod_t;

   // Reflected 32'h04C1_1DB7
   localparam word_t CRC32_POLY_REV  = 32'hEDB8_8320;

   // Reflected 32'h1EDC_6F41, Castagnoli
   localparam word_t CRC32C_POLY_REV = 32'h82F6_3B78;

endpackage

// ==== hdl/mul_op_pkg.sv ====
// Ops are 5 bits, top bit is the class; ten bit-manip functions, six spare codes give zero
package mul_op_pkg;

   typedef logic [4:0] op_t;
   typedef logic [3:0] bm_func_t;

   // Bit-manipulation function codes, the low bits of a class 1 op
   localparam bm_func_t FN_GREV     = 4'd0;
   localparam bm_func_t FN_GORC     = 4'd1;
   localparam bm_func_t FN_SHFL     = 4'd2;
   localparam bm_func_t FN_UNSHFL   = 4'd3;
   localparam bm_func_t FN_CRC32_B  = 4'd4;
   localparam bm_func_t FN_CRC32_H  = 4'd5;
   localparam bm_func_t FN_CRC32_W  = 4'd6;
   localparam bm_func_t FN_CRC32C_B = 4'd7;
   localparam bm_func_t FN_CRC32C_H = 4'd8;
   localparam bm_func_t FN_CRC32C_W = 4'd9;

   // Multiply ops, spare codes 0_0100 to 0_1111 act as OP_MUL
   localparam op_t OP_MUL    = 5'b0_0000;
   localparam op_t OP_MULH   = 5'b0_0001;
   localparam op_t OP_MULHSU = 5'b0_0010;
   localparam op_t OP_MULHU  = 5'b0_0011;

   localparam op_t OP_GREV     = {1'b1, FN_GREV};
   localparam op_t OP_GORC     = {1'b1, FN_GORC};
   localparam op_t OP_SHFL     = {1'b1, FN_SHFL};
   localparam op_t OP_UNSHFL   = {1'b1, FN_UNSHFL};
   localparam op_t OP_CRC32_B  = {1'b1, FN_CRC32_B};
   localparam op_t OP_CRC32_H  = {1'b1, FN_CRC32_H};
   localparam op_t OP_CRC32_W  = {1'b1, FN_CRC32_W};
   localparam op_t OP_CRC32C_B = {1'b1, FN_CRC32C_B};
   localparam op_t OP_CRC32C_H = {1'b1, FN_CRC32C_H};
   localparam op_t OP_CRC32C_W = {1'b1, FN_CRC32C_W};

   // Class rule, 1 selects the bit-manipulation result
   function automatic logic op_is_bitmanip(op_t op);
      return op[4];
   endfunction

   function automatic bm_func_t op_func(op_t op);
      return op[3:0];
   endfunction

endpackage
